// File: verilog/icache_pkg.sv
package icache_pkg;

	// fixed bus widths
	localparam int ADDR_WIDTH  = 32;
	localparam int FETCH_WIDTH = 64;
	localparam int BEAT_WIDTH  = 32;

	// one instruction fetch word
	typedef logic [FETCH_WIDTH-1:0] fetch_word_t;

	// cpu to cache
	typedef struct packed {
		logic                  read;
		logic                  flush_1;
		logic                  flush_2;
		logic [ADDR_WIDTH-1:0] address;
	} ibus_req_t;

	// cache to cpu
	typedef struct packed {
		logic        stall;
		logic        valid;
		fetch_word_t rddata;
	} ibus_resp_t;

	// axi read address channel plus rready, driven by the master
	typedef struct packed {
		logic                  arvalid;
		logic [ADDR_WIDTH-1:0] araddr;
		logic [7:0]            arlen;
		logic [2:0]            arsize;
		logic [1:0]            arburst;
		logic                  rready;
	} axi_ar_req_t;

	// driven by the slave
	typedef struct packed {
		logic                  arready;
		logic                  rvalid;
		logic [BEAT_WIDTH-1:0] rdata;
		logic                  rlast;
	} axi_r_resp_t;

endpackage

// File: verilog/single_port_ram.sv
module single_port_ram #(
	parameter int  DEPTH = 64,
	parameter type dtype = logic [31:0]
) (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     we,
	input  logic [$clog2(DEPTH)-1:0] addr,
	input  dtype                     din,
	output dtype                     dout
);

	dtype mem [DEPTH];

	// registered read, write data shows on dout at once
	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			for (int i = 0; i < DEPTH; i++) begin
				mem[i] <= '0;
			end
			dout <= '0;
		end else if (we) begin
			mem[addr] <= din;
			dout      <= din;
		end else begin
			dout <= mem[addr];
		end
	end

endmodule

// File: verilog/axi_refill.sv
module axi_refill #(
	parameter int LINE_WIDTH = 256
) (
	input  logic                              clk,
	input  logic                              rst,
	input  logic                              miss_start,
	input  logic [icache_pkg::ADDR_WIDTH-1:0] miss_addr,
	input  logic                              flush_2,
	output icache_pkg::axi_ar_req_t           axi_req,
	input  icache_pkg::axi_r_resp_t           axi_resp,
	output logic                              refill_we,
	output logic [LINE_WIDTH-1:0]             refill_line
);

	import icache_pkg::*;

	localparam int BEATS       = LINE_WIDTH / BEAT_WIDTH;
	localparam int LINE_OFFSET = $clog2(LINE_WIDTH / 8);

	typedef logic [BEATS-1:0][BEAT_WIDTH-1:0] beats_t;

	typedef enum logic [2:0] {
		IDLE,
		WAIT_AR,
		RECEIVING,
		FLUSH_WAIT_AR,
		FLUSH_RECEIVING,
		FINISH
	} state_t;

	state_t                   state;
	state_t                   state_d;
	logic [$clog2(BEATS)-1:0] beat_cnt;
	beats_t                   line_buf;
	beats_t                   line_out;
	logic [ADDR_WIDTH-1:0]    line_addr;
	logic                     beat;
	logic                     last_beat;

	assign beat      = axi_resp.rvalid & axi_req.rready;
	assign last_beat = beat & axi_resp.rlast;

	always_comb begin
		axi_req         = '0;
		axi_req.araddr  = line_addr;
		axi_req.arlen   = 8'(BEATS - 1);
		axi_req.arsize  = 3'b010;  // 4 byte beats
		axi_req.arburst = 2'b01;   // incr
		axi_req.arvalid = (state == WAIT_AR) || (state == FLUSH_WAIT_AR);
		axi_req.rready  = (state == RECEIVING) || (state == FLUSH_RECEIVING);
	end

	// last beat goes straight into the top slot
	always_comb begin
		line_out           = line_buf;
		line_out[BEATS-1]  = axi_resp.rdata;
	end

	assign refill_line = line_out;
	assign refill_we   = (state == RECEIVING) & last_beat & ~flush_2;

	always_comb begin
		state_d = state;
		unique case (state)
			IDLE:
				if (miss_start)
					state_d = WAIT_AR;
			WAIT_AR:
				if (axi_resp.arready)
					state_d = flush_2 ? FLUSH_RECEIVING : RECEIVING;
				else if (flush_2)
					state_d = FLUSH_WAIT_AR;
			FLUSH_WAIT_AR:
				if (axi_resp.arready)
					state_d = FLUSH_RECEIVING;
			RECEIVING:
				if (last_beat)
					state_d = FINISH;
				else if (flush_2)
					state_d = FLUSH_RECEIVING;
			FLUSH_RECEIVING:
				if (last_beat)
					state_d = FINISH;
			FINISH:
				state_d = IDLE;
			default:
				state_d = IDLE;
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			state    <= IDLE;
			beat_cnt <= '0;
		end else begin
			state <= state_d;
			if (axi_req.arvalid && axi_resp.arready)
				beat_cnt <= '0;
			else if (beat)
				beat_cnt <= beat_cnt + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && miss_start)
			line_addr <= {miss_addr[ADDR_WIDTH-1:LINE_OFFSET], {LINE_OFFSET{1'b0}}};
		if (beat)
			line_buf[beat_cnt] <= axi_resp.rdata;
	end

endmodule

// File: verilog/icache.sv
module icache #(
	parameter int LINE_WIDTH  = 256,
	parameter int SET_ASSOC   = 4,
	parameter int CACHE_BYTES = 512
) (
	input  logic                              clk,
	input  logic                              rst,
	input  icache_pkg::ibus_req_t             ibus_req,
	output icache_pkg::ibus_resp_t            ibus_resp,
	output logic                              miss_start,
	output logic [icache_pkg::ADDR_WIDTH-1:0] miss_addr,
	input  logic                              refill_we,
	input  logic [LINE_WIDTH-1:0]             refill_line
);

	import icache_pkg::*;

	localparam int LINE_BYTES  = LINE_WIDTH / 8;
	localparam int SETS        = CACHE_BYTES / LINE_BYTES / SET_ASSOC;
	localparam int WORDS       = LINE_WIDTH / FETCH_WIDTH;
	localparam int WORD_OFFSET = $clog2(FETCH_WIDTH / 8);
	localparam int LINE_OFFSET = $clog2(LINE_BYTES);
	localparam int INDEX_WIDTH = $clog2(SETS);
	localparam int TAG_WIDTH   = ADDR_WIDTH - INDEX_WIDTH - LINE_OFFSET;
	localparam int WAY_BITS    = $clog2(SET_ASSOC);

	typedef struct packed {
		logic                 valid;
		logic [TAG_WIDTH-1:0] tag;
	} tag_t;

	typedef logic [WORDS-1:0][FETCH_WIDTH-1:0] line_t;
	typedef logic [INDEX_WIDTH-1:0] index_t;
	typedef logic [LINE_OFFSET-WORD_OFFSET-1:0] word_sel_t;

	function automatic index_t get_index(input logic [ADDR_WIDTH-1:0] addr);
		return addr[LINE_OFFSET+INDEX_WIDTH-1:LINE_OFFSET];
	endfunction

	function automatic logic [TAG_WIDTH-1:0] get_tag(input logic [ADDR_WIDTH-1:0] addr);
		return addr[ADDR_WIDTH-1:LINE_OFFSET+INDEX_WIDTH];
	endfunction

	function automatic word_sel_t get_word(input logic [ADDR_WIDTH-1:0] addr);
		return addr[LINE_OFFSET-1:WORD_OFFSET];
	endfunction

	// stage 2
	logic                  pipe_read;
	logic [ADDR_WIDTH-1:0] pipe_addr;

	tag_t  [SET_ASSOC-1:0] tag_rdata;
	line_t [SET_ASSOC-1:0] data_rdata;
	tag_t                  tag_wdata;
	line_t                 data_wdata;
	logic  [SET_ASSOC-1:0] way_we;
	index_t                ram_addr;

	logic [SET_ASSOC-1:0] hit;
	logic                 any_hit;
	logic                 stall;
	logic                 valid;
	fetch_word_t          rd_word;

	logic [7:0]          lfsr;
	logic [WAY_BITS-1:0] victim;

	for (genvar i = 0; i < SET_ASSOC; i++) begin : gen_hit
		assign hit[i] = tag_rdata[i].valid && (tag_rdata[i].tag == get_tag(pipe_addr));
	end
	assign any_hit = |hit;

	assign stall = pipe_read & ~any_hit & ~ibus_req.flush_2;
	assign valid = pipe_read & any_hit & ~ibus_req.flush_2;

	// at most one way hits
	always_comb begin
		rd_word = '0;
		for (int i = 0; i < SET_ASSOC; i++) begin
			rd_word |= {FETCH_WIDTH{hit[i]}} & data_rdata[i][get_word(pipe_addr)];
		end
	end

	assign ibus_resp = '{stall: stall, valid: valid, rddata: rd_word};

	assign miss_start = stall;
	assign miss_addr  = pipe_addr;

	// keep reading the stalled set so the refilled line shows up
	assign ram_addr = stall ? get_index(pipe_addr) : get_index(ibus_req.address);

	assign victim          = lfsr[WAY_BITS-1:0];
	assign tag_wdata.valid = 1'b1;
	assign tag_wdata.tag   = get_tag(pipe_addr);
	assign data_wdata      = refill_line;

	always_comb begin
		way_we         = '0;
		way_we[victim] = refill_we;
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			pipe_read <= 1'b0;
			pipe_addr <= '0;
		end else if (!stall) begin
			pipe_read <= ibus_req.read & ~ibus_req.flush_1;
			pipe_addr <= ibus_req.address;
		end
	end

	// x^8 + x^6 + x^5 + x^4 + 1
	always_ff @(posedge clk or posedge rst) begin
		if (rst)
			lfsr <= 8'h5a;
		else if (refill_we)
			lfsr <= {lfsr[6:0], lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3]};
	end

	for (genvar i = 0; i < SET_ASSOC; i++) begin : gen_way
		single_port_ram #(
			.DEPTH (SETS),
			.dtype (tag_t)
		) tag_ram (
			.clk  (clk),
			.rst  (rst),
			.we   (way_we[i]),
			.addr (ram_addr),
			.din  (tag_wdata),
			.dout (tag_rdata[i])
		);

		single_port_ram #(
			.DEPTH (SETS),
			.dtype (line_t)
		) data_ram (
			.clk  (clk),
			.rst  (rst),
			.we   (way_we[i]),
			.addr (ram_addr),
			.din  (data_wdata),
			.dout (data_rdata[i])
		);
	end

endmodule

// File: verilog/icache_top.sv
module icache_top #(
	parameter int LINE_WIDTH  = 256,
	parameter int SET_ASSOC   = 4,
	parameter int CACHE_BYTES = 512
) (
	input  logic                    clk,
	input  logic                    rst,
	input  icache_pkg::ibus_req_t   ibus_req,
	output icache_pkg::ibus_resp_t  ibus_resp,
	output icache_pkg::axi_ar_req_t axi_req,
	input  icache_pkg::axi_r_resp_t axi_resp
);

	import icache_pkg::*;

	logic                  miss_start;
	logic [ADDR_WIDTH-1:0] miss_addr;
	logic                  refill_we;
	logic [LINE_WIDTH-1:0] refill_line;

	icache #(
		.LINE_WIDTH  (LINE_WIDTH),
		.SET_ASSOC   (SET_ASSOC),
		.CACHE_BYTES (CACHE_BYTES)
	) icache_inst (
		.clk         (clk),
		.rst         (rst),
		.ibus_req    (ibus_req),
		.ibus_resp   (ibus_resp),
		.miss_start  (miss_start),
		.miss_addr   (miss_addr),
		.refill_we   (refill_we),
		.refill_line (refill_line)
	);

	// flush_2 goes to the refill directly, it decides on dropping the line
	axi_refill #(
		.LINE_WIDTH (LINE_WIDTH)
	) axi_refill_inst (
		.clk         (clk),
		.rst         (rst),
		.miss_start  (miss_start),
		.miss_addr   (miss_addr),
		.flush_2     (ibus_req.flush_2),
		.axi_req     (axi_req),
		.axi_resp    (axi_resp),
		.refill_we   (refill_we),
		.refill_line (refill_line)
	);

endmodule

// File: verification/axi_mem_model.sv
module axi_mem_model (
	input  logic                    clk,
	input  logic                    rst,
	input  icache_pkg::axi_ar_req_t axi_req,
	output icache_pkg::axi_r_resp_t axi_resp
);

	timeunit 1ns;
	timeprecision 100ps;

	import icache_pkg::*;

	integer                seed;
	logic                  busy;
	logic [ADDR_WIDTH-1:0] base;
	logic [7:0]            cnt;
	logic [7:0]            len;
	logic                  ar_fire;
	logic                  r_fire;
	logic [ADDR_WIDTH-1:0] ar_addr;
	logic [7:0]            ar_len;

	// memory contents follow a rule on the byte address
	function automatic logic [BEAT_WIDTH-1:0] word_at(input logic [ADDR_WIDTH-1:0] a);
		return {a[31:2], 2'b01} ^ 32'hA5A5_0000;
	endfunction

	initial begin
		seed     = 97658;
		busy     = 1'b0;
		base     = '0;
		cnt      = '0;
		len      = '0;
		axi_resp = '0;
		forever begin
			// handshakes are judged mid cycle, outputs change after the edge
			@(negedge clk);
			ar_fire = axi_req.arvalid & axi_resp.arready;
			r_fire  = axi_resp.rvalid & axi_req.rready;
			ar_addr = axi_req.araddr;
			ar_len  = axi_req.arlen;
			@(posedge clk);
			#1;
			if (rst) begin
				busy     = 1'b0;
				axi_resp = '0;
			end else begin
				if (r_fire) begin
					if (cnt == len)
						busy = 1'b0;
					cnt = cnt + 8'd1;
				end
				if (ar_fire) begin
					busy = 1'b1;
					base = ar_addr;
					len  = ar_len;
					cnt  = '0;
				end
				axi_resp.arready = !busy && (($random(seed) & 3) != 0);
				// an offered beat stays until taken
				if (!(axi_resp.rvalid && !r_fire)) begin
					if (busy && (($random(seed) & 1) != 0)) begin
						axi_resp.rvalid = 1'b1;
						axi_resp.rdata  = word_at(base + {22'b0, cnt, 2'b00});
						axi_resp.rlast  = (cnt == len);
					end else begin
						axi_resp.rvalid = 1'b0;
						axi_resp.rlast  = 1'b0;
					end
				end
			end
		end
	end

endmodule

// File: verification/icache_assert.sv
module icache_assert (
	input logic                    clk,
	input logic                    rst,
	input icache_pkg::ibus_resp_t  ibus_resp,
	input icache_pkg::axi_ar_req_t axi_req,
	input icache_pkg::axi_r_resp_t axi_resp,
	input logic                    refill_we
);

	timeunit 1ns;
	timeprecision 100ps;

	// address must hold while the slave is not ready
	ar_stable: assert property (@(posedge clk) disable iff (rst)
		axi_req.arvalid && !axi_resp.arready |=> axi_req.arvalid && $stable(axi_req.araddr))
		else $error("araddr changed or arvalid dropped before arready");

	valid_stall_excl: assert property (@(posedge clk) disable iff (rst)
		!(ibus_resp.valid && ibus_resp.stall))
		else $error("valid and stall high in the same cycle");

	// finish cycle and idle cycle come first
	no_early_ar: assert property (@(posedge clk) disable iff (rst)
		refill_we |=> !axi_req.arvalid ##1 !axi_req.arvalid)
		else $error("new arvalid right after refill_we");

endmodule

bind icache_top icache_assert icache_assert_inst (
	.clk       (clk),
	.rst       (rst),
	.ibus_resp (ibus_resp),
	.axi_req   (axi_req),
	.axi_resp  (axi_resp),
	.refill_we (refill_we)
);

// File: verification/icache_tb.sv
module icache_tb;

	timeunit 1ns;
	timeprecision 100ps;

	import icache_pkg::*;

	localparam int LINE_WIDTH  = 256;
	localparam int SET_ASSOC   = 4;
	localparam int CACHE_BYTES = 512;
	localparam int LINE_BYTES  = LINE_WIDTH / 8;

	logic        clk;
	logic        rst;
	ibus_req_t   ibus_req;
	ibus_resp_t  ibus_resp;
	axi_ar_req_t axi_req;
	axi_r_resp_t axi_resp;

	// one trace entry per slot
	byte                   kinds[$];
	logic [ADDR_WIDTH-1:0] t_addr[$];
	logic                  t_f1[$];
	logic                  t_f2[$];
	fetch_word_t           t_data[$];

	fetch_word_t           pending[$];
	logic [ADDR_WIDTH-1:0] refills[$];
	logic [ADDR_WIDTH-1:0] requested[$];
	int                    cycles;
	int                    limit;

	icache_top #(
		.LINE_WIDTH  (LINE_WIDTH),
		.SET_ASSOC   (SET_ASSOC),
		.CACHE_BYTES (CACHE_BYTES)
	) icache_top_inst (
		.clk       (clk),
		.rst       (rst),
		.ibus_req  (ibus_req),
		.ibus_resp (ibus_resp),
		.axi_req   (axi_req),
		.axi_resp  (axi_resp)
	);

	axi_mem_model mem_inst (
		.clk      (clk),
		.rst      (rst),
		.axi_req  (axi_req),
		.axi_resp (axi_resp)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	task automatic check_fetch(input fetch_word_t got, input fetch_word_t exp);
		if (got !== exp) begin
			$display("[ERROR] %0t ibus_resp.rddata got %h expected %h", $time, got, exp);
			fail_now("fetch data mismatch");
		end
	endtask

	task automatic check_refill(input logic [ADDR_WIDTH-1:0] got,
		input logic [ADDR_WIDTH-1:0] exp);
		if (got !== exp) begin
			$display("[ERROR] %0t axi_req.araddr got %h expected %h", $time, got, exp);
			fail_now("refill address mismatch");
		end
	endtask

	// one line per burst of 4 byte beats, incrementing
	task automatic check_burst(input axi_ar_req_t got);
		if (got.arlen !== 8'(LINE_WIDTH / BEAT_WIDTH - 1)) begin
			$display("[ERROR] %0t axi_req.arlen got %h expected %h", $time, got.arlen,
				8'(LINE_WIDTH / BEAT_WIDTH - 1));
			fail_now("burst length mismatch");
		end
		if (got.arsize !== 3'($clog2(BEAT_WIDTH / 8))) begin
			$display("[ERROR] %0t axi_req.arsize got %h expected %h", $time, got.arsize,
				3'($clog2(BEAT_WIDTH / 8)));
			fail_now("burst size mismatch");
		end
		if (got.arburst !== 2'b01) begin
			$display("[ERROR] %0t axi_req.arburst got %h expected %h", $time, got.arburst,
				2'b01);
			fail_now("burst type mismatch");
		end
	endtask

	task automatic check_flag(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			$display("[ERROR] %0t %s got %b expected %b", $time, name, got, exp);
			fail_now("control signal mismatch");
		end
	endtask

	function automatic logic [ADDR_WIDTH-1:0] line_of(input logic [ADDR_WIDTH-1:0] a);
		return a & ~ADDR_WIDTH'(LINE_BYTES - 1);
	endfunction

	// responses in request order
	always @(negedge clk) begin
		if (!rst && ibus_resp.valid) begin
			if (pending.size() == 0)
				fail_now("valid seen while no accepted request was waiting for data");
			else
				check_fetch(ibus_resp.rddata, pending.pop_front());
		end
	end

	always @(negedge clk) begin
		if (!rst && axi_req.arvalid && axi_resp.arready) begin
			check_burst(axi_req);
			refills.push_back(axi_req.araddr);
		end
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (limit > 0 && cycles >= limit)
			fail_now("timeout: a handshake never completed and the DUT seems stuck");
	end

	task automatic load_trace();
		int                    fd;
		int                    n;
		string                 line;
		string                 kind;
		logic [ADDR_WIDTH-1:0] a;
		int                    f1;
		int                    f2;
		fetch_word_t           d;
		fd = $fopen("verification/icache_trace.txt", "r");
		if (fd == 0) begin
			fail_now("cannot open verification/icache_trace.txt");
		end else begin
			while ($fgets(line, fd) != 0) begin
				if (line.len() > 1 && line[0] != "#") begin
					a  = '0;
					f1 = 0;
					f2 = 0;
					d  = '0;
					if (line[0] == "F") begin
						n = $sscanf(line, "%s %h %d %d %h", kind, a, f1, f2, d);
						if (n != 5)
							fail_now("malformed fetch line in the trace file");
					end else if (line[0] == "R") begin
						n = $sscanf(line, "%s %h", kind, a);
						if (n != 2)
							fail_now("malformed refill line in the trace file");
					end
					kinds.push_back(line[0]);
					t_addr.push_back(a);
					t_f1.push_back(f1[0]);
					t_f2.push_back(f2[0]);
					t_data.push_back(d);
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic bus_idle();
		ibus_req = '0;
	endtask

	task automatic wait_idle();
		while (pending.size() != 0 || ibus_resp.stall || axi_req.arvalid || axi_req.rready) begin
			@(posedge clk);
			#1;
		end
	endtask

	task automatic do_fetch(input logic [ADDR_WIDTH-1:0] addr, input logic f1,
		input logic f2, input fetch_word_t exp);
		logic accepted;
		int   seen;
		if (f1) begin
			wait_idle();
			seen = refills.size();
			ibus_req = '{read: 1'b1, flush_1: 1'b1, flush_2: 1'b0, address: addr};
			@(posedge clk);
			#1;
			bus_idle();
			repeat (4) begin
				@(negedge clk);
				check_flag("ibus_resp.stall", ibus_resp.stall, 1'b0);
			end
			@(posedge clk);
			#1;
			if (refills.size() != seen)
				fail_now("a request dropped by flush_1 started a refill");
		end else begin
			ibus_req = '{read: 1'b1, flush_1: 1'b0, flush_2: 1'b0, address: addr};
			accepted = 1'b0;
			while (!accepted) begin
				@(negedge clk);
				accepted = !ibus_resp.stall;
				@(posedge clk);
			end
			if (!f2)
				pending.push_back(exp);
			requested.push_back(line_of(addr));
			#1;
			bus_idle();
			if (f2) begin
				// cancel stage 2 once the burst is running
				while (!axi_req.rready) begin
					@(posedge clk);
					#1;
				end
				ibus_req.flush_2 = 1'b1;
				@(posedge clk);
				#1;
				ibus_req.flush_2 = 1'b0;
			end
		end
	endtask

	task automatic expect_refill(input logic [ADDR_WIDTH-1:0] exp);
		while (refills.size() == 0) begin
			@(posedge clk);
			#1;
		end
		check_refill(refills.pop_front(), exp);
	endtask

	// refills not listed in the trace come from random evictions
	task automatic drain_refills();
		logic [ADDR_WIDTH-1:0] a;
		logic                  found;
		wait_idle();
		while (refills.size() != 0) begin
			a     = refills.pop_front();
			found = 1'b0;
			foreach (requested[i])
				if (requested[i] == a)
					found = 1'b1;
			if (a != line_of(a))
				fail_now("refill address is not line aligned");
			else if (!found)
				fail_now("refill address belongs to no requested line");
		end
	endtask

	initial begin
		ibus_req = '0;
		rst      = 1'b1;
		cycles   = 0;
		limit    = 0;
		load_trace();
		limit = kinds.size() * 64;
		repeat (4) @(posedge clk);
		#1;
		rst = 1'b0;
		repeat (3) begin
			@(negedge clk);
			check_flag("ibus_resp.valid", ibus_resp.valid, 1'b0);
			check_flag("ibus_resp.stall", ibus_resp.stall, 1'b0);
			check_flag("axi_req.arvalid", axi_req.arvalid, 1'b0);
		end
		@(posedge clk);
		#1;
		for (int i = 0; i < kinds.size(); i++) begin
			case (kinds[i])
				"F": do_fetch(t_addr[i], t_f1[i], t_f2[i], t_data[i]);
				"R": expect_refill(t_addr[i]);
				"D": drain_refills();
				default: fail_now("unknown line kind in the trace file");
			endcase
		end
		wait_idle();
		if (pending.size() != 0 || refills.size() != 0) begin
			fail_now("responses or refills left over at the end of the trace");
		end else begin
			$display("ALL TESTS PASSED");
			$finish;
		end
	end

endmodule

// File: verification/icache_trace.txt
# F <address hex> <flush_1> <flush_2> <expected rddata hex>
# R <expected refill line address hex>    D  drain and check unlisted refills
F 00001000 0 0 A5A51005A5A51001
R 00001000
F 00001008 0 0 A5A5100DA5A51009
F 00001010 0 0 A5A51015A5A51011
F 00001018 0 0 A5A5101DA5A51019
F 00003020 0 0 A5A53025A5A53021
R 00003020
F 000030A8 0 0 A5A530ADA5A530A9
R 000030A0
F 00003130 0 0 A5A53135A5A53131
R 00003120
F 000031B8 0 0 A5A531BDA5A531B9
R 000031A0
F 00003220 0 0 A5A53225A5A53221
R 00003220
F 00003038 0 0 A5A5303DA5A53039
F 000030A0 0 0 A5A530A5A5A530A1
F 00003128 0 0 A5A5312DA5A53129
F 000031B0 0 0 A5A531B5A5A531B1
F 00003238 0 0 A5A5323DA5A53239
D
F 00004040 0 1 0000000000000000
R 00004040
F 00004048 0 0 A5A5404DA5A54049
R 00004040
F 00005060 1 0 0000000000000000
F 00005060 0 0 A5A55065A5A55061
R 00005060
F 00001018 0 0 A5A5101DA5A51019
F 00001000 0 0 A5A51005A5A51001
F 00001010 0 0 A5A51015A5A51011
F 00001008 0 0 A5A5100DA5A51009
F 00005068 0 0 A5A5506DA5A55069
F 00005070 0 0 A5A55075A5A55071
F 00005078 0 0 A5A5507DA5A55079
F 00004058 0 0 A5A5405DA5A54059
F 00004050 0 0 A5A54055A5A54051

// File: tb.f
verilog/icache_pkg.sv
verilog/single_port_ram.sv
verilog/axi_refill.sv
verilog/icache.sv
verilog/icache_top.sv
verification/axi_mem_model.sv
verification/icache_assert.sv
verification/icache_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= icache_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
PASS_TEXT ?= ALL TESTS PASSED

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; status=$$?; echo "$$out"; \
	[ $$status -eq 0 ] && echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
